/* scatter_top.f */
design/scatter_data_pkg.sv
design/scatter_ctrl_pkg.sv
design/priority_encoder.sv
design/array_zero_mask.sv
design/scatter_threshold.sv
design/scatter_stats.sv
design/scatter_top.sv
test/tb_clock_gen.sv
test/scatter_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the scatter unit testbench with Verilator and run it.
# The run counts as passed only when the pass line shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module scatter_top_tb -f scatter_top.f -o scatter_sim \
  && ./obj_dir/scatter_sim | tee /dev/stderr | grep -q "RESULT: PASS" \
  && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }

/* test/scatter_top_tb.sv */
`timescale 1ns/1ps

module scatter_top_tb;

  import scatter_data_pkg::*;
  import scatter_ctrl_pkg::*;

  localparam int clk_period = 20;
  localparam int stream_len = 40;
  // Reset, idle, two boundary runs, two overflow runs, stream, statistics
  localparam int test_cycles = 9 + 7 + 2 * 4 + 2 * 4 + (stream_len + 3) + 14;
  localparam int timeout_ns  = test_cycles * clk_period + 1000;
  localparam int hex_w       = $bits(scatter_res_t);

  typedef logic [hex_w-1:0] hexval_t;

  logic           clk;
  logic           arst_n;
  logic           in_valid;
  vec_t           in_data;
  threshold_t     threshold;
  scan_order_e    scan_order;
  logic           stats_clear;
  logic           out_valid;
  scatter_res_t   out_res;
  scatter_stats_t stats;

  int             errors;
  int             vec_sent;
  int             seed;
  scatter_stats_t exp_stats;
  scatter_res_t   last_res;
  vec_t           stim_data[$];
  threshold_t     stim_thr[$];
  scan_order_e    stim_ord[$];

  tb_clock_gen #(.period(clk_period), .rst_cycles(8)) clk0 (
    .clk    (clk),
    .arst_n (arst_n)
  );

  scatter_top dut0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .threshold   (threshold),
    .scan_order  (scan_order),
    .stats_clear (stats_clear),
    .out_valid   (out_valid),
    .out_res     (out_res),
    .stats       (stats)
  );

  task automatic report_mismatch(input string name, input hexval_t exp_v, input hexval_t act_v);
    errors++;
    $display("FAILED %s: expected 0x%0h, got 0x%0h", name, exp_v, act_v);
  endtask

  // Expected result straight from the threshold, scan and slot rules
  function automatic scatter_res_t model_result(input vec_t d, input threshold_t t,
                                                input scan_order_e o);
    scatter_res_t r;
    logic [vec_len-1:0] taken;
    int lim;
    int val;
    int pos;
    int hits;

    r     = '0;
    taken = '0;
    lim   = int'(t);
    hits  = 0;
    for (int step = 0; step < vec_len; step++) begin
      pos = (o == scan_high_first) ? vec_len - 1 - step : step;
      val = int'(d[pos]);
      if (val > lim || val < -lim) begin
        if (hits < num_slots) begin
          taken[pos]         = 1'b1;
          r.high[pos]        = d[pos];
          r.slot_val[hits]   = d[pos];
          r.slot_idx[hits]   = idx_t'(pos);
          r.slot_valid[hits] = 1'b1;
        end
        hits++;
      end
    end
    for (int i = 0; i < vec_len; i++) begin
      if (!taken[i]) r.low[i] = d[i];
    end
    r.overflow = hits > num_slots;
    return r;
  endfunction

  function automatic count_t bump_counter(input count_t c, input int n);
    int sum;

    sum = int'(c) + n;
    return (sum > (1 << stat_w) - 1) ? '1 : count_t'(sum);
  endfunction

  task automatic queue_vec(input vec_t d, input threshold_t t, input scan_order_e o);
    stim_data.push_back(d);
    stim_thr.push_back(t);
    stim_ord.push_back(o);
  endtask

  // Drive queued vectors on consecutive cycles and expect each two edges later
  task automatic play_stimulus();
    scatter_res_t exp_q[$];
    vec_t         data_q[$];
    scatter_res_t exp_r;
    vec_t         in_v;
    int           n;

    n = stim_data.size();
    for (int j = 0; j < n + 3; j++) begin
      if (j >= 2 && j - 2 < n) begin
        exp_r = exp_q.pop_front();
        in_v  = data_q.pop_front();
        exp_stats.vec_count      = bump_counter(exp_stats.vec_count, 1);
        exp_stats.outlier_count  = bump_counter(exp_stats.outlier_count,
                                                int'(exp_r.slot_valid[0]) +
                                                int'(exp_r.slot_valid[1]));
        exp_stats.overflow_count = bump_counter(exp_stats.overflow_count, int'(exp_r.overflow));
        if (out_valid !== 1'b1) report_mismatch("out_valid", hexval_t'(1), hexval_t'(out_valid));
        if (out_res !== exp_r) report_mismatch("out_res", hexval_t'(exp_r), hexval_t'(out_res));
        if ((out_res.high | out_res.low) !== in_v) begin
          report_mismatch("out_res.high|low", hexval_t'(in_v),
                          hexval_t'(out_res.high | out_res.low));
        end
        last_res = out_res;
      end else if (out_valid !== 1'b0) begin
        report_mismatch("out_valid", hexval_t'(0), hexval_t'(out_valid));
      end
      if (stats !== exp_stats) report_mismatch("stats", hexval_t'(exp_stats), hexval_t'(stats));
      if (j < n) begin
        in_valid   = 1'b1;
        in_data    = stim_data[j];
        threshold  = stim_thr[j];
        scan_order = stim_ord[j];
        exp_q.push_back(model_result(stim_data[j], stim_thr[j], stim_ord[j]));
        data_q.push_back(stim_data[j]);
        vec_sent++;
      end else begin
        in_valid = 1'b0;
      end
      @(posedge clk);
      #2;
    end
    stim_data.delete();
    stim_thr.delete();
    stim_ord.delete();
  endtask

  task automatic pulse_clear();
    stats_clear = 1'b1;
    @(posedge clk);
    #2;
    stats_clear = 1'b0;
    exp_stats   = '0;
    if (stats !== '0) report_mismatch("stats", hexval_t'(0), hexval_t'(stats));
  endtask

  task automatic expect_counts(input int v, input int o, input int f);
    if (stats.vec_count !== count_t'(v)) report_mismatch("stats.vec_count", v, stats.vec_count);
    if (stats.outlier_count !== count_t'(o)) begin
      report_mismatch("stats.outlier_count", hexval_t'(o), hexval_t'(stats.outlier_count));
    end
    if (stats.overflow_count !== count_t'(f)) begin
      report_mismatch("stats.overflow_count", hexval_t'(f), hexval_t'(stats.overflow_count));
    end
  endtask

  // +-6 sit on the threshold and +-7 just outside
  function automatic vec_t boundary_vec();
    vec_t v;

    v[0] = 16'sd6;
    v[1] = -16'sd6;
    v[2] = 16'sd7;
    v[3] = -16'sd7;
    v[4] = 16'sd0;
    v[5] = 16'sd3;
    v[6] = -16'sd5;
    v[7] = 16'sd6;
    return v;
  endfunction

  // Five outliers over threshold 100 at indices 1 2 4 5 7
  function automatic vec_t overflow_vec();
    vec_t v;

    v[0] = 16'sd5;
    v[1] = 16'sd200;
    v[2] = -16'sd300;
    v[3] = 16'sd50;
    v[4] = 16'sd1000;
    v[5] = -16'sd101;
    v[6] = -16'sd100;
    v[7] = 16'sd32767;
    return v;
  endfunction

  task automatic reset_idle_test();
    if (out_valid !== 1'b0) report_mismatch("out_valid", hexval_t'(0), hexval_t'(out_valid));
    if (out_res !== '0) report_mismatch("out_res", hexval_t'(0), hexval_t'(out_res));
    if (stats !== '0) report_mismatch("stats", hexval_t'(0), hexval_t'(stats));
    repeat (6) begin
      @(posedge clk);
      #2;
      if (out_valid !== 1'b0) begin
        $display("Output strobe rose while no vector was presented");
        errors++;
      end
    end
  endtask

  task automatic boundary_test();
    queue_vec(boundary_vec(), threshold_t'(6), scan_low_first);
    play_stimulus();
    if (last_res.slot_idx[0] !== 3'd2) report_mismatch("slot_idx[0]", 2, last_res.slot_idx[0]);
    if (last_res.slot_val[1] !== -16'sd7) begin
      report_mismatch("slot_val[1]", hexval_t'(16'hfff9), hexval_t'(last_res.slot_val[1]));
    end
    if (last_res.low[1] !== -16'sd6) begin
      report_mismatch("low[1]", hexval_t'(16'hfffa), hexval_t'(last_res.low[1]));
    end
    queue_vec(boundary_vec(), threshold_t'(6), scan_high_first);
    play_stimulus();
    if (last_res.slot_idx[0] !== 3'd3) report_mismatch("slot_idx[0]", 3, last_res.slot_idx[0]);
    if (last_res.high[2] !== 16'sd7) report_mismatch("high[2]", 7, last_res.high[2]);
  endtask

  task automatic overflow_order_test();
    queue_vec(overflow_vec(), threshold_t'(100), scan_low_first);
    play_stimulus();
    if (last_res.slot_idx[0] !== 3'd1) report_mismatch("slot_idx[0]", 1, last_res.slot_idx[0]);
    if (last_res.slot_idx[1] !== 3'd2) report_mismatch("slot_idx[1]", 2, last_res.slot_idx[1]);
    if (last_res.overflow !== 1'b1) report_mismatch("overflow", 1, last_res.overflow);
    if (last_res.low[4] !== 16'sd1000) report_mismatch("low[4]", 1000, last_res.low[4]);
    queue_vec(overflow_vec(), threshold_t'(100), scan_high_first);
    play_stimulus();
    if (last_res.slot_idx[0] !== 3'd7) report_mismatch("slot_idx[0]", 7, last_res.slot_idx[0]);
    if (last_res.slot_idx[1] !== 3'd5) report_mismatch("slot_idx[1]", 5, last_res.slot_idx[1]);
    if (last_res.low[1] !== 16'sd200) report_mismatch("low[1]", 200, last_res.low[1]);
  endtask

  task automatic random_stream_test();
    vec_t v;

    for (int k = 0; k < stream_len; k++) begin
      for (int i = 0; i < vec_len; i++) begin
        v[i] = elem_t'($random(seed) % 4096);
      end
      queue_vec(v, threshold_t'({$random(seed)} % 4096), scan_order_e'($random(seed) & 1));
    end
    play_stimulus();
  endtask

  task automatic stats_test();
    pulse_clear();
    queue_vec(boundary_vec(), threshold_t'(6), scan_low_first);
    queue_vec(overflow_vec(), threshold_t'(100), scan_high_first);
    queue_vec('0, threshold_t'(0), scan_low_first);
    play_stimulus();
    expect_counts(3, 4, 1);
    pulse_clear();
    // Counting picks up again after the clear
    queue_vec(overflow_vec(), threshold_t'(100), scan_low_first);
    play_stimulus();
    expect_counts(1, 2, 1);
  endtask

  initial begin
    #(timeout_ns);
    $display("Timeout: run did not finish within %0d ns", timeout_ns);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    errors      = 0;
    vec_sent    = 0;
    seed        = 80;
    exp_stats   = '0;
    last_res    = '0;
    in_valid    = 1'b0;
    in_data     = '0;
    threshold   = '0;
    scan_order  = scan_low_first;
    stats_clear = 1'b0;

    @(posedge arst_n);
    @(posedge clk);
    #2;
    reset_idle_test();
    boundary_test();
    overflow_order_test();
    random_stream_test();
    stats_test();

    $display("Finished %0d vectors with %0d errors", vec_sent, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period     = 20,
  parameter int rst_cycles = 8
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Release lands between edges away from the sampling point
  initial begin
    arst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    #2;
    arst_n = 1'b1;
  end

endmodule

/* design/scatter_top.sv */
`timescale 1ns/1ps

module scatter_top (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             in_valid,
  input  scatter_data_pkg::vec_t           in_data,
  input  scatter_ctrl_pkg::threshold_t     threshold,
  input  scatter_ctrl_pkg::scan_order_e    scan_order,
  input  logic                             stats_clear,
  output logic                             out_valid,
  output scatter_data_pkg::scatter_res_t   out_res,
  output scatter_ctrl_pkg::scatter_stats_t stats
);

  import scatter_data_pkg::*;
  import scatter_ctrl_pkg::*;

  // Stage-1 payload captured as one unit
  typedef struct packed {
    vec_t        data;
    threshold_t  threshold;
    scan_order_e order;
  } s1_t;

  s1_t          s1_q;
  logic         s1_valid;
  scatter_res_t res_comb;
  logic [1:0]   granted;
  req_t         out_high_nz;
  req_t         out_low_nz;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  // Payload only moves with a valid vector
  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_q.data      <= in_data;
      s1_q.threshold <= threshold;
      s1_q.order     <= scan_order;
    end
  end

  scatter_threshold thr0 (
    .data      (s1_q.data),
    .threshold (s1_q.threshold),
    .order     (s1_q.order),
    .res       (res_comb)
  );

  // Output register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      out_res   <= '0;
    end else begin
      out_valid <= s1_valid;
      if (s1_valid) begin
        out_res <= res_comb;
      end
    end
  end

  assign granted = 2'($countones(res_comb.slot_valid));

  // Counts land on the same edge as the output register
  scatter_stats stats0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .clear     (stats_clear),
    .res_valid (s1_valid),
    .granted   (granted),
    .overflow  (res_comb.overflow),
    .stats     (stats)
  );

  for (genvar i = 0; i < vec_len; i++) begin : g_nz
    assign out_high_nz[i] = out_res.high[i] != '0;
    assign out_low_nz[i]  = out_res.low[i] != '0;
  end

  a_out_valid_known: assert property (
    @(posedge clk) disable iff (!arst_n) !$isunknown(out_valid)
  );

  a_high_within_slots: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid |-> ($countones(out_high_nz) <= num_slots)
  );

  a_high_low_disjoint: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid |-> ((out_high_nz & out_low_nz) == '0)
  );

endmodule

/* design/scatter_stats.sv */
`timescale 1ns/1ps

module scatter_stats (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            clear,
  input  logic                            res_valid,
  input  logic [1:0]                      granted,
  input  logic                            overflow,
  output scatter_ctrl_pkg::scatter_stats_t stats
);

  import scatter_data_pkg::*;
  import scatter_ctrl_pkg::*;

  // Add and stick at all ones
  function automatic count_t sat_add(input count_t base, input count_t inc);
    logic [stat_w:0] sum;

    sum = {1'b0, base} + {1'b0, inc};
    return sum[stat_w] ? '1 : sum[stat_w-1:0];
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stats <= '0;
    end else if (clear) begin
      // Clear wins over a result on the same edge
      stats <= '0;
    end else if (res_valid) begin
      stats.vec_count      <= sat_add(stats.vec_count, count_t'(1));
      stats.outlier_count  <= sat_add(stats.outlier_count, count_t'(granted));
      stats.overflow_count <= sat_add(stats.overflow_count, count_t'(overflow));
    end
  end

  // Slot count from the encoder must fit the slot budget
  a_granted_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    res_valid |-> (32'(granted) <= num_slots)
  );

endmodule

/* design/scatter_threshold.sv */
`timescale 1ns/1ps

module scatter_threshold (
  input  scatter_data_pkg::vec_t        data,
  input  scatter_ctrl_pkg::threshold_t  threshold,
  input  scatter_ctrl_pkg::scan_order_e order,
  output scatter_data_pkg::scatter_res_t res
);

  import scatter_data_pkg::*;

  // Signed bounds from the zero-extended threshold
  elem_t thr_pos;
  elem_t thr_neg;

  req_t                  req;
  req_t                  grant_mask;
  idx_t [num_slots-1:0]  slot_idx;
  logic [num_slots-1:0]  slot_valid;
  logic [3:0]            req_count;
  elem_t [num_slots-1:0] slot_val;
  vec_t                  high;
  vec_t                  low;

  assign thr_pos = elem_t'({1'b0, threshold});
  assign thr_neg = -thr_pos;

  // Strictly outside [-thr, +thr]
  for (genvar i = 0; i < vec_len; i++) begin : g_req
    assign req[i] = (data[i] > thr_pos) || (data[i] < thr_neg);
  end

  priority_encoder enc0 (
    .req        (req),
    .order      (order),
    .grant_mask (grant_mask),
    .slot_idx   (slot_idx),
    .slot_valid (slot_valid),
    .req_count  (req_count)
  );

  array_zero_mask mask0 (
    .data (data),
    .mask (grant_mask),
    .high (high),
    .low  (low)
  );

  // Gather granted values into the compact slots
  for (genvar s = 0; s < num_slots; s++) begin : g_slot
    assign slot_val[s] = slot_valid[s] ? data[slot_idx[s]] : elem_t'(0);
  end

  always_comb begin
    res.high       = high;
    res.low        = low;
    res.slot_val   = slot_val;
    res.slot_idx   = slot_idx;
    res.slot_valid = slot_valid;
    // More outliers than slots
    res.overflow   = req_count > 4'(num_slots);
  end

endmodule

/* design/array_zero_mask.sv */
`timescale 1ns/1ps

module array_zero_mask (
  input  scatter_data_pkg::vec_t data,
  input  scatter_data_pkg::req_t mask,
  output scatter_data_pkg::vec_t high,
  output scatter_data_pkg::vec_t low
);

  import scatter_data_pkg::*;

  // Each element lands on exactly one side and the other side gets zero
  for (genvar i = 0; i < vec_len; i++) begin : g_elem
    // Masked elements go to the high path
    assign high[i] = mask[i] ? data[i] : elem_t'(0);

    // Everything else stays on the low path
    assign low[i]  = mask[i] ? elem_t'(0) : data[i];
  end

endmodule

/* design/priority_encoder.sv */
`timescale 1ns/1ps

module priority_encoder (
  input  scatter_data_pkg::req_t                                    req,
  input  scatter_ctrl_pkg::scan_order_e                             order,
  output scatter_data_pkg::req_t                                    grant_mask,
  output scatter_data_pkg::idx_t [scatter_data_pkg::num_slots-1:0] slot_idx,
  output logic [scatter_data_pkg::num_slots-1:0]                    slot_valid,
  output logic [3:0]                                                req_count
);

  import scatter_data_pkg::*;
  import scatter_ctrl_pkg::*;

  // Element position visited at each scan step
  idx_t [vec_len-1:0] scan_pos;

  for (genvar i = 0; i < vec_len; i++) begin : g_scan
    assign scan_pos[i] = (order == scan_high_first) ? idx_t'(vec_len - 1 - i) : idx_t'(i);
  end

  // Walk requests in scan order and hand out slots to the first hits.
  // Every request is counted whether granted or not
  always_comb begin
    int   filled;
    idx_t pos;

    grant_mask = '0;
    slot_idx   = '0;
    slot_valid = '0;
    req_count  = '0;
    filled     = 0;

    for (int i = 0; i < vec_len; i++) begin
      pos = scan_pos[i];
      if (req[pos]) begin
        req_count = req_count + 4'd1;
        // Slot 0 takes the first hit
        if (filled < num_slots) begin
          grant_mask[pos]    = 1'b1;
          slot_idx[filled]   = pos;
          slot_valid[filled] = 1'b1;
          filled             = filled + 1;
        end
      end
    end
  end

endmodule

/* design/scatter_ctrl_pkg.sv */
package scatter_ctrl_pkg;

  // Width of each statistics counter
  localparam int stat_w = 16;

  // Threshold magnitude is one bit short of an element
  localparam int thr_w = 15;

  // Order in which the encoder walks the request bits
  typedef enum logic {
    scan_low_first  = 1'b0,
    scan_high_first = 1'b1
  } scan_order_e;

  typedef logic [thr_w-1:0] threshold_t;

  typedef logic [stat_w-1:0] count_t;

  typedef struct packed {
    count_t vec_count;
    count_t outlier_count;
    count_t overflow_count;
  } scatter_stats_t;

endpackage

/* design/scatter_data_pkg.sv */
package scatter_data_pkg;

  // Element width in bits
  localparam int precision = 16;

  // Elements per vector
  localparam int vec_len = 8;

  // High-precision slots per vector
  localparam int num_slots = 2;

  // Enough bits to address any element
  localparam int idx_w = 3;

  typedef logic signed [precision-1:0] elem_t;

  // Element 0 sits in the low bits
  typedef elem_t [vec_len-1:0] vec_t;

  typedef logic [idx_w-1:0] idx_t;

  // One request or grant bit per element
  typedef logic [vec_len-1:0] req_t;

  // Everything produced for one vector
  typedef struct packed {
    vec_t                  high;
    vec_t                  low;
    elem_t [num_slots-1:0] slot_val;
    idx_t [num_slots-1:0]  slot_idx;
    logic [num_slots-1:0]  slot_valid;
    logic                  overflow;
  } scatter_res_t;

endpackage
